//--- include/ahb_mst_defines.svh
//====================================================================
// ahb master bus constants
// widths and AHB encodings shared by the master and its testbench
//====================================================================

`ifndef AHB_MST_DEFINES_SVH
`define AHB_MST_DEFINES_SVH

// bus widths
`define AHB_ADDR_W      32
`define AHB_DATA_W      32
`define AHB_THRES_W     4

// htrans codes
`define HTRANS_IDLE     2'b00
`define HTRANS_BUSY     2'b01
`define HTRANS_NONSEQ   2'b10
`define HTRANS_SEQ      2'b11

// hburst, hsize and hresp codes
`define HBURST_SINGLE   3'b000
`define HBURST_INCR4    3'b011
`define HSIZE_WORD      3'b010
`define HRESP_OKAY      2'b00
`define HRESP_ERROR     2'b01

// INCR4 shape
`define BURST_BEATS     4
`define ADDR_STEP       4

`endif

//--- verilog/ahb_mst_pkg.sv
//====================================================================
// ahb master types
// vector types of the bus fields and the address FSM states
//====================================================================

`include "ahb_mst_defines.svh"

package ahb_mst_pkg;

	// bus payload
	typedef logic [`AHB_ADDR_W-1:0]  addr_t;
	typedef logic [`AHB_DATA_W-1:0]  data_t;

	// timeout threshold in hclk cycles
	typedef logic [`AHB_THRES_W-1:0] thres_t;

	// AHB control fields
	typedef logic [1:0] htrans_t;
	typedef logic [2:0] hburst_t;
	typedef logic [2:0] hsize_t;
	typedef logic [1:0] hresp_t;

	// beat index inside an INCR4
	typedef logic [1:0] beat_cnt_t;

	// idle, or beats of a single / burst command still to present
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_SINGLE = 2'd1,
		ST_BURST  = 2'd2
	} mst_state_e;

endpackage

//--- verilog/ahb_mst_beat_if.sv
//====================================================================
// ahb master beat status
// per-beat handshake between address, data and fault blocks
//====================================================================

`timescale 1ns/1ps

interface ahb_mst_beat_if;

	// address phase accepted this cycle
	logic issue;
	// direction and final-beat flag of that beat
	logic write;
	logic last;
	// a data phase is on the bus
	logic pending;
	// kill the transfer now
	logic abort;

	modport addr (output issue, output write, output last, input abort);

	modport data (input issue, input write, input last, input abort, output pending);

	modport fault (input pending, output abort);

endinterface

//--- verilog/ahb_mst_addr_ctrl.sv
//====================================================================
// ahb master address control
// accepts one command at a time and drives the address phase,
// NONSEQ then SEQ for INCR4, BUSY while write data is late
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_addr_ctrl
	import ahb_mst_pkg::*;
(
	input  logic         ahb_hclk,
	input  logic         ahb_hrstn,
	input  logic         clr,
	input  logic         cmd_valid,
	input  logic         cmd_write,
	input  logic         cmd_burst,
	input  addr_t        cmd_addr,
	output logic         cmd_ready,
	input  logic         wdata_valid,
	input  logic         ahb_hready,
	output htrans_t      ahb_htrans,
	output hburst_t      ahb_hburst,
	output hsize_t       ahb_hsize,
	output logic         ahb_hwrite,
	output addr_t        ahb_haddr,
	ahb_mst_beat_if.addr beat
);

	// command still owing address phases
	mst_state_e state;
	beat_cnt_t  beat_cnt;
	addr_t      nxt_addr;
	logic       cmd_write_r;

	// beat currently sitting on the address bus
	logic       slot_vld;
	logic       slot_first;
	logic       slot_last;

	logic       hs;
	logic       load;

	// where the next beat comes from
	logic       src_vld;
	addr_t      src_addr;
	logic       src_write;
	logic       src_burst;
	beat_cnt_t  src_cnt;
	logic       src_last;

	// new command only once the previous one has presented its last beat
	assign cmd_ready = (state == ST_IDLE) && !clr && !beat.abort;
	assign hs = cmd_valid && cmd_ready;

	// write beats show up only with data in hand
	always_comb
	begin
		if (!slot_vld)
			ahb_htrans = `HTRANS_IDLE;
		else if (ahb_hwrite && !wdata_valid)
			ahb_htrans = slot_first ? `HTRANS_IDLE : `HTRANS_BUSY;
		else
			ahb_htrans = slot_first ? `HTRANS_NONSEQ : `HTRANS_SEQ;
	end

	assign ahb_hsize  = `HSIZE_WORD;
	assign beat.issue = ahb_htrans[1] && ahb_hready;
	assign beat.write = ahb_hwrite;
	assign beat.last  = slot_last;

	// slot refills when its beat goes out or when it is empty
	assign load = beat.issue || (ahb_hready && !slot_vld);

	// straight from the command port when idle, else from the latched command
	assign src_vld   = (state != ST_IDLE) || hs;
	assign src_addr  = (state == ST_IDLE) ? cmd_addr : nxt_addr;
	assign src_write = (state == ST_IDLE) ? cmd_write : cmd_write_r;
	assign src_burst = (state == ST_IDLE) ? cmd_burst : (state == ST_BURST);
	assign src_cnt   = (state == ST_IDLE) ? beat_cnt_t'(0) : beat_cnt;
	assign src_last  = !src_burst || (src_cnt == beat_cnt_t'(`BURST_BEATS - 1));

	//====================================================================
	// FSM and address phase registers
	//====================================================================

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			state      <= ST_IDLE;
			beat_cnt   <= '0;
			slot_vld   <= 1'b0;
			slot_first <= 1'b0;
			slot_last  <= 1'b0;
			ahb_haddr  <= '0;
			ahb_hwrite <= 1'b0;
			ahb_hburst <= `HBURST_SINGLE;
		end
		else if (clr || beat.abort)
		begin
			// drop everything, IDLE on the bus next cycle
			state      <= ST_IDLE;
			beat_cnt   <= '0;
			slot_vld   <= 1'b0;
			slot_first <= 1'b0;
			slot_last  <= 1'b0;
			ahb_hburst <= `HBURST_SINGLE;
		end
		else if (load)
		begin
			slot_vld   <= src_vld;
			slot_first <= src_vld && (src_cnt == beat_cnt_t'(0));
			slot_last  <= src_vld && src_last;
			ahb_hburst <= (src_vld && src_burst) ? `HBURST_INCR4 : `HBURST_SINGLE;
			if (src_vld)
			begin
				ahb_haddr  <= src_addr;
				ahb_hwrite <= src_write;
			end
			// idle again as soon as the final beat is on the bus
			if (src_vld && !src_last)
			begin
				state    <= ST_BURST;
				beat_cnt <= src_cnt + 1'b1;
			end
			else
				state <= ST_IDLE;
		end
		else if (hs)
		begin
			// bus still busy, park the command
			state    <= cmd_burst ? ST_BURST : ST_SINGLE;
			beat_cnt <= '0;
		end
	end

	// latched command fields
	always_ff @(posedge ahb_hclk)
	begin
		if (hs)
			cmd_write_r <= cmd_write;
		if (load && src_vld)
			nxt_addr <= src_addr + addr_t'(`ADDR_STEP);
		else if (hs)
			nxt_addr <= cmd_addr;
	end

endmodule

//--- verilog/ahb_mst_data_ctrl.sv
//====================================================================
// ahb master data control
// tracks the data phase, stages write words, flags read data and done
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_data_ctrl
	import ahb_mst_pkg::*;
(
	input  logic         ahb_hclk,
	input  logic         ahb_hrstn,
	input  logic         clr,
	input  logic         ahb_hready,
	input  data_t        wdata,
	output logic         wdata_ready,
	output data_t        ahb_hwdata,
	input  data_t        ahb_hrdata,
	output data_t        rdata,
	output logic         rdata_valid,
	output logic         done,
	ahb_mst_beat_if.data beat
);

	// data phase state, one beat behind the address phase
	logic pending_r;
	logic d_write;
	logic d_last;
	// data phase completes this cycle
	logic d_end;

	assign beat.pending = pending_r;

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			pending_r <= 1'b0;
			d_write   <= 1'b0;
			d_last    <= 1'b0;
		end
		else if (clr || beat.abort)
			pending_r <= 1'b0;
		else if (ahb_hready)
		begin
			// next data phase exists only if a beat went out now
			pending_r <= beat.issue;
			if (beat.issue)
			begin
				d_write <= beat.write;
				d_last  <= beat.last;
			end
		end
	end

	// write word taken with its address phase
	assign wdata_ready = beat.issue && beat.write;

	// held on hwdata through the data phase and its wait states
	always_ff @(posedge ahb_hclk)
	begin
		if (wdata_ready)
			ahb_hwdata <= wdata;
	end

	assign d_end = pending_r && ahb_hready && !beat.abort;

	// read data passes straight through
	assign rdata       = ahb_hrdata;
	assign rdata_valid = d_end && !d_write;
	assign done        = d_end && d_last;

endmodule

//--- verilog/ahb_mst_fault_mon.sv
//====================================================================
// ahb master fault monitor
// hready timeout and ERROR response detection, raises abort
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_fault_mon
	import ahb_mst_pkg::*;
(
	input  logic          ahb_hclk,
	input  logic          ahb_hrstn,
	input  logic          clr,
	input  logic          ahb_hready,
	input  hresp_t        ahb_hresp,
	input  thres_t        thres,
	output logic          hready_to,
	output logic          hresp_err,
	ahb_mst_beat_if.fault beat
);

	// wait-state count of the current data phase
	thres_t to_cnt;
	// all-ones threshold turns the timeout off
	logic   to_off;

	assign to_off = &thres;

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			to_cnt <= '0;
		else if (clr || ahb_hready || !beat.pending || to_off)
			to_cnt <= '0;
		else if (!hready_to)
			to_cnt <= to_cnt + 1'b1;
	end

	assign hready_to = beat.pending && !ahb_hready && !to_off && (to_cnt == thres);

	// first cycle of the two-cycle ERROR response
	assign hresp_err = beat.pending && !ahb_hready && (ahb_hresp == `HRESP_ERROR);

	assign beat.abort = hready_to || hresp_err;

endmodule

//--- verilog/ahb_mst_fault_regs.sv
//====================================================================
// ahb master fault registers
// timeout threshold and sticky interrupt status bits
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_fault_regs
	import ahb_mst_pkg::*;
(
	input  logic       ahb_hclk,
	input  logic       ahb_hrstn,
	input  logic       cfg_thres_wr,
	input  thres_t     cfg_thres,
	input  logic [1:0] irq_clr,
	input  logic       hready_to,
	input  logic       hresp_err,
	output thres_t     thres,
	output logic       irq_hready_to,
	output logic       irq_hresp_err
);

	// comes up all ones, timeout disabled
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			thres <= '1;
		else if (cfg_thres_wr)
			thres <= cfg_thres;
	end

	// irq_clr[0] clears timeout, irq_clr[1] clears error
	// a new fault wins over a clear in the same cycle
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			irq_hready_to <= 1'b0;
			irq_hresp_err <= 1'b0;
		end
		else
		begin
			if (hready_to)
				irq_hready_to <= 1'b1;
			else if (irq_clr[0])
				irq_hready_to <= 1'b0;
			if (hresp_err)
				irq_hresp_err <= 1'b1;
			else if (irq_clr[1])
				irq_hresp_err <= 1'b0;
		end
	end

endmodule

//--- verilog/ahb_mst_top.sv
//====================================================================
// ahb master top
// Ethernet DMA bus master with fault monitor and its registers
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_top
	import ahb_mst_pkg::*;
(
	input  logic       ahb_hclk,
	input  logic       ahb_hrstn,
	input  logic       clr,
	// command channel
	input  logic       cmd_valid,
	input  logic       cmd_write,
	input  logic       cmd_burst,
	input  addr_t      cmd_addr,
	output logic       cmd_ready,
	// write and read data
	input  logic       wdata_valid,
	input  data_t      wdata,
	output logic       wdata_ready,
	output data_t      rdata,
	output logic       rdata_valid,
	output logic       done,
	// AHB master side
	output htrans_t    ahb_htrans,
	output hburst_t    ahb_hburst,
	output hsize_t     ahb_hsize,
	output logic       ahb_hwrite,
	output addr_t      ahb_haddr,
	output data_t      ahb_hwdata,
	input  logic       ahb_hready,
	input  hresp_t     ahb_hresp,
	input  data_t      ahb_hrdata,
	// configuration and interrupts
	input  logic       cfg_thres_wr,
	input  thres_t     cfg_thres,
	input  logic [1:0] irq_clr,
	output logic       irq_hready_to,
	output logic       irq_hresp_err
);

	thres_t thres;
	logic   hready_to;
	logic   hresp_err;

	ahb_mst_beat_if u_beat_if ();

	//====================================================================
	// address and data phases
	//====================================================================

	ahb_mst_addr_ctrl u_addr_ctrl (
		.ahb_hclk    (ahb_hclk),
		.ahb_hrstn   (ahb_hrstn),
		.clr         (clr),
		.cmd_valid   (cmd_valid),
		.cmd_write   (cmd_write),
		.cmd_burst   (cmd_burst),
		.cmd_addr    (cmd_addr),
		.cmd_ready   (cmd_ready),
		.wdata_valid (wdata_valid),
		.ahb_hready  (ahb_hready),
		.ahb_htrans  (ahb_htrans),
		.ahb_hburst  (ahb_hburst),
		.ahb_hsize   (ahb_hsize),
		.ahb_hwrite  (ahb_hwrite),
		.ahb_haddr   (ahb_haddr),
		.beat        (u_beat_if.addr)
	);

	ahb_mst_data_ctrl u_data_ctrl (
		.ahb_hclk    (ahb_hclk),
		.ahb_hrstn   (ahb_hrstn),
		.clr         (clr),
		.ahb_hready  (ahb_hready),
		.wdata       (wdata),
		.wdata_ready (wdata_ready),
		.ahb_hwdata  (ahb_hwdata),
		.ahb_hrdata  (ahb_hrdata),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.done        (done),
		.beat        (u_beat_if.data)
	);

	//====================================================================
	// fault handling
	//====================================================================

	ahb_mst_fault_mon u_fault_mon (
		.ahb_hclk   (ahb_hclk),
		.ahb_hrstn  (ahb_hrstn),
		.clr        (clr),
		.ahb_hready (ahb_hready),
		.ahb_hresp  (ahb_hresp),
		.thres      (thres),
		.hready_to  (hready_to),
		.hresp_err  (hresp_err),
		.beat       (u_beat_if.fault)
	);

	ahb_mst_fault_regs u_fault_regs (
		.ahb_hclk      (ahb_hclk),
		.ahb_hrstn     (ahb_hrstn),
		.cfg_thres_wr  (cfg_thres_wr),
		.cfg_thres     (cfg_thres),
		.irq_clr       (irq_clr),
		.hready_to     (hready_to),
		.hresp_err     (hresp_err),
		.thres         (thres),
		.irq_hready_to (irq_hready_to),
		.irq_hresp_err (irq_hresp_err)
	);

endmodule

//--- sim/ahb_mst_asserts.sv
//====================================================================
// ahb master bus protocol checks
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_asserts
	import ahb_mst_pkg::*;
(
	input logic       ahb_hclk,
	input logic       ahb_hrstn,
	input logic       clr,
	input logic       ahb_hready,
	input logic       cmd_valid,
	input logic       cmd_burst,
	input logic       cmd_ready,
	input logic       abort,
	input htrans_t    ahb_htrans,
	input addr_t      ahb_haddr
);

	// address of the last accepted beat
	addr_t last_addr;
	// address phases handed over but not yet accepted
	logic [2:0] owed;

	always_ff @(posedge ahb_hclk)
	begin
		if (ahb_htrans[1] && ahb_hready)
			last_addr <= ahb_haddr;
	end

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			owed <= '0;
		else if (clr || abort)
			owed <= '0;
		else
			owed <= owed
				+ ((cmd_valid && cmd_ready) ? (cmd_burst ? 3'(`BURST_BEATS) : 3'd1) : 3'd0)
				- ((ahb_htrans[1] && ahb_hready) ? 3'd1 : 3'd0);
	end

	// address phase frozen through wait states unless aborted
	assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		(ahb_htrans[1] && !ahb_hready && !abort) |=>
		(ahb_htrans == $past(ahb_htrans) && ahb_haddr == $past(ahb_haddr)))
		else $error("address phase changed during a wait state");

	assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		(ahb_htrans == `HTRANS_SEQ) |-> (ahb_haddr == last_addr + addr_t'(`ADDR_STEP)))
		else $error("SEQ address does not follow the previous beat");

	// idle means at most the final beat is still on the address bus
	assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		cmd_ready |-> (owed <= 3'd1))
		else $error("cmd_ready high while earlier beats are still owed");

endmodule

bind ahb_mst_top ahb_mst_asserts u_asserts (
	.ahb_hclk   (ahb_hclk),
	.ahb_hrstn  (ahb_hrstn),
	.clr        (clr),
	.ahb_hready (ahb_hready),
	.cmd_valid  (cmd_valid),
	.cmd_burst  (cmd_burst),
	.cmd_ready  (cmd_ready),
	.abort      (u_beat_if.abort),
	.ahb_htrans (ahb_htrans),
	.ahb_haddr  (ahb_haddr)
);

//--- sim/ahb_mst_tb.sv
//====================================================================
// ahb master testbench
// slave memory model, table of commands, timeout and fault checks
//====================================================================

`timescale 1ns/1ps

`include "ahb_mst_defines.svh"

module ahb_mst_tb
	import ahb_mst_pkg::*;
;

	// one table row, waits of 3 means random 0..2
	typedef struct packed
	{
		logic       write;
		logic       burst;
		addr_t      addr;
		logic [1:0] waits;
		logic       inject;
		logic [2:0] hold;
		logic       exp_irq;
	} row_t;

	logic ahb_hclk = 1'b0;
	logic ahb_hrstn;
	logic clr, cmd_valid, cmd_write, cmd_burst, cmd_ready;
	addr_t cmd_addr, ahb_haddr;
	logic wdata_valid, wdata_ready, rdata_valid, done, ahb_hwrite, ahb_hready;
	data_t wdata, rdata, ahb_hwdata, ahb_hrdata;
	htrans_t ahb_htrans;
	hburst_t ahb_hburst;
	hsize_t ahb_hsize;
	hresp_t ahb_hresp;
	logic cfg_thres_wr;
	thres_t cfg_thres;
	logic [1:0] irq_clr;
	logic irq_hready_to, irq_hresp_err;

	// slave model state
	data_t sl_mem [0:63];
	data_t exp_mem [0:63];
	logic dp_vld, dp_write, dp_err, err_st;
	addr_t dp_addr;
	logic [1:0] wait_left, beat_idx, sl_waits;
	logic sl_inject, sl_stall;

	// stimulus and monitor bookkeeping
	row_t rows[$];
	data_t wq[$];
	data_t rq[$];
	addr_t aq[$];
	htrans_t tq[$];
	hburst_t bq[$];
	hsize_t sq[$];
	int hold_left, cur_hold, done_cnt, wr_cnt, tot_done, n_cmd, err_cnt, n_test;

	always #5 ahb_hclk = ~ahb_hclk;

	ahb_mst_top u_ahb_mst_top (.*);

	//====================================================================
	// AHB slave model
	//====================================================================

	always @(posedge ahb_hclk or negedge ahb_hrstn)
	begin : slave_seq
		logic [1:0] nxt_idx;
		if (!ahb_hrstn)
		begin
			dp_vld    <= 1'b0;
			dp_err    <= 1'b0;
			err_st    <= 1'b0;
			wait_left <= '0;
			beat_idx  <= '0;
		end
		else if (ahb_hready)
		begin
			// finished write phase lands in memory
			if (dp_vld && dp_write && !dp_err)
				sl_mem[dp_addr[7:2]] <= ahb_hwdata;
			nxt_idx = (ahb_htrans == `HTRANS_NONSEQ) ? 2'd0 : beat_idx + 2'd1;
			dp_vld    <= ahb_htrans[1];
			dp_addr   <= ahb_haddr;
			dp_write  <= ahb_hwrite;
			beat_idx  <= nxt_idx;
			dp_err    <= ahb_htrans[1] && sl_inject && (nxt_idx == 2'd1);
			err_st    <= 1'b0;
			wait_left <= (sl_waits == 2'd3) ? 2'($urandom_range(2, 0)) : sl_waits;
		end
		else if (dp_err)
			err_st <= 1'b1;
		else if (wait_left != 2'd0)
			wait_left <= wait_left - 2'd1;
	end

	// two-cycle ERROR, wait states, stall
	always @(negedge ahb_hclk)
	begin
		ahb_hresp  = `HRESP_OKAY;
		ahb_hrdata = '0;
		if (!dp_vld)
			ahb_hready = 1'b1;
		else if (dp_err)
		begin
			ahb_hresp  = `HRESP_ERROR;
			ahb_hready = err_st;
		end
		else if (sl_stall || wait_left != 2'd0)
			ahb_hready = 1'b0;
		else
		begin
			ahb_hready = 1'b1;
			if (!dp_write)
				ahb_hrdata = sl_mem[dp_addr[7:2]];
		end
	end

	//====================================================================
	// write data driver and monitors
	//====================================================================

	always @(negedge ahb_hclk)
	begin
		if (hold_left != 0)
		begin
			wdata_valid = 1'b0;
			hold_left   = hold_left - 1;
		end
		else if (wq.size() != 0)
		begin
			wdata_valid = 1'b1;
			wdata       = wq[0];
		end
		else
			wdata_valid = 1'b0;
	end

	always @(posedge ahb_hclk)
	begin
		if (ahb_hrstn)
		begin
			if (done)
			begin
				done_cnt = done_cnt + 1;
				tot_done = tot_done + 1;
			end
			if (wdata_ready)
			begin
				wr_cnt = wr_cnt + 1;
				void'(wq.pop_front());
				hold_left = cur_hold;
			end
			if (rdata_valid)
				rq.push_back(rdata);
			if (ahb_htrans[1] && ahb_hready)
			begin
				aq.push_back(ahb_haddr);
				tq.push_back(ahb_htrans);
				bq.push_back(ahb_hburst);
				sq.push_back(ahb_hsize);
			end
		end
	end

	//====================================================================
	// compare and wait helpers
	//====================================================================

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_burst(input string name, input hburst_t got, input hburst_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_size(input string name, input hsize_t got, input hsize_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic send_cmd(input logic w, input logic b, input addr_t a);
		int t;
		t = 0;
		@(negedge ahb_hclk);
		cmd_valid = 1'b1;
		cmd_write = w;
		cmd_burst = b;
		cmd_addr  = a;
		while (1)
		begin
			@(posedge ahb_hclk);
			if (cmd_ready)
				break;
			t++;
			if (t > 50)
				abort_run("cmd_ready");
		end
		@(negedge ahb_hclk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_done();
		int t;
		t = 0;
		while (done_cnt < 1)
		begin
			@(negedge ahb_hclk);
			t++;
			if (t > 200)
				abort_run("done");
		end
	endtask

	// slave back to no data phase
	task automatic wait_slave_idle();
		int t;
		t = 0;
		while (dp_vld)
		begin
			@(negedge ahb_hclk);
			t++;
			if (t > 50)
				abort_run("slave idle");
		end
	endtask

	task automatic pulse_irq_clr(input logic [1:0] bits);
		@(negedge ahb_hclk);
		irq_clr = bits;
		@(negedge ahb_hclk);
		irq_clr = 2'b00;
	endtask

	//====================================================================
	// one table row
	//====================================================================

	task automatic run_row(input row_t r);
		int beats, t, e0, i, idx;
		data_t wd;
		e0    = err_cnt;
		beats = r.burst ? `BURST_BEATS : 1;
		done_cnt = 0;
		wr_cnt   = 0;
		rq.delete();
		aq.delete();
		tq.delete();
		bq.delete();
		sq.delete();
		sl_waits  = r.waits;
		sl_inject = r.inject;
		cur_hold  = int'(r.hold);
		hold_left = int'(r.hold);
		if (r.write)
			for (i = 0; i < beats; i++)
			begin
				wd = $urandom;
				wq.push_back(wd);
				exp_mem[int'(r.addr[7:2]) + i] = wd;
			end
		send_cmd(r.write, r.burst, r.addr);
		if (r.inject)
		begin
			// slave reaches the faulty second beat
			t = 0;
			while (!(dp_vld && dp_err))
			begin
				@(negedge ahb_hclk);
				t++;
				if (t > 100)
					abort_run("ERROR response");
			end
			wait_slave_idle();
			check_count("done pulses", done_cnt, 0);
			check_count("rdata_valid pulses", rq.size(), r.write ? 0 : 1);
		end
		else
		begin
			n_cmd++;
			wait_done();
			wait_slave_idle();
			check_count("done pulses", done_cnt, 1);
			check_count("address beats", aq.size(), beats);
			for (i = 0; i < beats && i < aq.size(); i++)
			begin
				idx = int'(r.addr[7:2]) + i;
				check_addr("ahb_haddr", aq[i], r.addr + addr_t'(`ADDR_STEP * i));
				check_flag("ahb_htrans is SEQ", tq[i] == `HTRANS_SEQ, i != 0);
				check_burst("ahb_hburst", bq[i], r.burst ? `HBURST_INCR4 : `HBURST_SINGLE);
				check_size("ahb_hsize", sq[i], `HSIZE_WORD);
				if (r.write)
					check_data("memory word", sl_mem[idx], exp_mem[idx]);
				else if (i < rq.size())
					check_data("rdata", rq[i], exp_mem[idx]);
			end
			if (r.write)
				check_count("wdata_ready pulses", wr_cnt, beats);
			else
				check_count("rdata_valid pulses", rq.size(), beats);
		end
		check_flag("irq_hresp_err", irq_hresp_err, r.exp_irq);
		pulse_irq_clr(2'b11);
		$display("test %0d: %s", n_test, (err_cnt == e0) ? "ok" : "failed");
		n_test++;
	endtask

	//====================================================================
	// main sequence
	//====================================================================

	initial
	begin : main
		int i, t, e0;
		void'($urandom(32'hd2c44da5));
		ahb_hrstn = 1'b0;
		clr = 1'b0;
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_burst = 1'b0;
		cmd_addr = '0;
		wdata_valid = 1'b0;
		wdata = '0;
		ahb_hready = 1'b1;
		ahb_hresp = `HRESP_OKAY;
		ahb_hrdata = '0;
		cfg_thres_wr = 1'b0;
		cfg_thres = '1;
		irq_clr = 2'b00;
		sl_waits = 2'd0;
		sl_inject = 1'b0;
		sl_stall = 1'b0;
		hold_left = 0;
		cur_hold = 0;
		done_cnt = 0;
		wr_cnt = 0;
		tot_done = 0;
		n_cmd = 0;
		err_cnt = 0;
		n_test = 0;
		for (i = 0; i < 64; i++)
		begin
			// fill tied to the byte address
			sl_mem[i]  = 32'h5a5a0000 | (i * 4);
			exp_mem[i] = sl_mem[i];
		end

		// write burst addr waits inject hold irq
		rows.push_back({1'b1, 1'b0, 32'h10, 2'd0, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b0, 1'b0, 32'h10, 2'd0, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b1, 1'b1, 32'h40, 2'd0, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b0, 1'b1, 32'h40, 2'd0, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b1, 1'b1, 32'h80, 2'd0, 1'b0, 3'd2, 1'b0});
		rows.push_back({1'b0, 1'b1, 32'h80, 2'd1, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b1, 1'b1, 32'hc0, 2'd3, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b0, 1'b0, 32'hc4, 2'd3, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b1, 1'b0, 32'h20, 2'd3, 1'b0, 3'd1, 1'b0});
		rows.push_back({1'b0, 1'b1, 32'hc0, 2'd3, 1'b0, 3'd0, 1'b0});
		rows.push_back({1'b0, 1'b1, 32'h50, 2'd0, 1'b1, 3'd0, 1'b1});
		rows.push_back({1'b0, 1'b0, 32'h10, 2'd3, 1'b0, 3'd0, 1'b0});

		repeat (3) @(posedge ahb_hclk);
		@(negedge ahb_hclk);
		ahb_hrstn = 1'b1;

		foreach (rows[i])
			run_row(rows[i]);

		// hready timeout at threshold 3
		e0 = err_cnt;
		sl_waits = 2'd0;
		sl_inject = 1'b0;
		@(negedge ahb_hclk);
		cfg_thres_wr = 1'b1;
		cfg_thres = 4'd3;
		@(negedge ahb_hclk);
		cfg_thres_wr = 1'b0;
		done_cnt = 0;
		rq.delete();
		sl_stall = 1'b1;
		send_cmd(1'b0, 1'b0, 32'h20);
		t = 0;
		while (!irq_hready_to)
		begin
			@(negedge ahb_hclk);
			t++;
			if (t > 100)
				abort_run("irq_hready_to");
		end
		sl_stall = 1'b0;
		wait_slave_idle();
		check_count("done pulses", done_cnt, 0);
		check_count("rdata_valid pulses", rq.size(), 0);
		pulse_irq_clr(2'b01);
		check_flag("irq_hready_to", irq_hready_to, 1'b0);
		$display("test %0d: %s", n_test, (err_cnt == e0) ? "ok" : "failed");
		n_test++;

		// timeout disabled, long stall then normal end
		e0 = err_cnt;
		@(negedge ahb_hclk);
		cfg_thres_wr = 1'b1;
		cfg_thres = 4'hf;
		@(negedge ahb_hclk);
		cfg_thres_wr = 1'b0;
		done_cnt = 0;
		rq.delete();
		sl_stall = 1'b1;
		send_cmd(1'b0, 1'b0, 32'h24);
		repeat (30) @(negedge ahb_hclk);
		check_flag("irq_hready_to", irq_hready_to, 1'b0);
		sl_stall = 1'b0;
		n_cmd++;
		wait_done();
		if (rq.size() == 1)
			check_data("rdata", rq[0], exp_mem[9]);
		else
			check_count("rdata_valid pulses", rq.size(), 1);
		$display("test %0d: %s", n_test, (err_cnt == e0) ? "ok" : "failed");
		n_test++;

		check_count("total done pulses", tot_done, n_cmd);
		$display("tests %0d errors %0d", n_test, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
verilog/ahb_mst_pkg.sv
verilog/ahb_mst_beat_if.sv
verilog/ahb_mst_addr_ctrl.sv
verilog/ahb_mst_data_ctrl.sv
verilog/ahb_mst_fault_mon.sv
verilog/ahb_mst_fault_regs.sv
verilog/ahb_mst_top.sv
sim/ahb_mst_asserts.sv
sim/ahb_mst_tb.sv

//--- Makefile
# Verilator build and run of the AHB master testbench

VERILATOR ?= verilator
TOP       ?= ahb_mst_tb
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
